//--- include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// datapath and address width
`define MIPS_XLEN 32

// architectural registers, r0 included
`define MIPS_NREGS 32

// first fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

// contents of a pipeline register holding a bubble
`define MIPS_STAGE_DEFAULT '0

`endif

//--- logic/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [$clog2(`MIPS_NREGS)-1:0] regIdx_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_M,
        FWD_W
    } fwdSel_e;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } memReq_t;

    typedef struct packed {
        logic   regWrite;
        aluOp_e aluOp;
        logic   useImm;
        logic   load;
        logic   store;
    } ctrl_t;

    typedef struct packed {
        ctrl_t   ctrl;
        regIdx_t rs;
        regIdx_t rt;
        regIdx_t dst;
        word_t   rsVal;
        word_t   rtVal;
        word_t   imm;
        word_t   pc;
    } deReg_t;

    typedef struct packed {
        ctrl_t   ctrl;
        regIdx_t dst;
        word_t   aluRes;
        word_t   storeData;
        word_t   pc;
    } emReg_t;

    typedef struct packed {
        word_t   pc;
        regIdx_t rd;
        word_t   value;
    } retire_t;

endpackage

//--- logic/fetchUnit.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module fetchUnit (
    input  logic            clk_i,
    input  logic            rstN_i,
    input  logic            stall_i,
    input  logic            grant_i,
    input  logic            redirect_i,
    input  mips_pkg::word_t target_i,
    input  mips_pkg::word_t instr_i,
    output logic            fetchReq_o,
    output mips_pkg::word_t pc_o,
    output mips_pkg::word_t instrD_o,
    output mips_pkg::word_t pcD_o,
    output logic            validD_o
);

    mips_pkg::word_t pcQ;
    mips_pkg::word_t pcPlus4;
    logic            pendValid;
    mips_pkg::word_t pendTarget;

    assign pcPlus4    = pcQ + mips_pkg::word_t'(4);
    assign fetchReq_o = ~stall_i;
    assign pc_o       = pcQ;

    // a redirect seen while the delay slot lost its grant waits here
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            pcQ       <= `MIPS_RESET_PC;
            pendValid <= 1'b0;
            validD_o  <= 1'b0;
        end else if (!stall_i) begin
            validD_o <= grant_i;
            if (grant_i) begin
                pendValid <= 1'b0;
                if (pendValid) begin
                    pcQ <= pendTarget;
                end else if (redirect_i) begin
                    pcQ <= target_i;
                end else begin
                    pcQ <= pcPlus4;
                end
            end else if (redirect_i) begin
                pendValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            if (grant_i) begin
                instrD_o <= instr_i;
                pcD_o    <= pcQ;
            end else if (redirect_i) begin
                pendTarget <= target_i;
            end
        end
    end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module regFile (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  logic              we_i,
    input  mips_pkg::regIdx_t wAddr_i,
    input  mips_pkg::word_t   wData_i,
    input  mips_pkg::regIdx_t rAddrA_i,
    input  mips_pkg::regIdx_t rAddrB_i,
    output mips_pkg::word_t   rDataA_o,
    output mips_pkg::word_t   rDataB_o
);

    // r0 has no storage
    mips_pkg::word_t regs [1:`MIPS_NREGS-1];

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 1; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wAddr_i != '0) begin
            regs[wAddr_i] <= wData_i;
        end
    end

    // write data bypasses to a same-cycle read
    assign rDataA_o = (rAddrA_i == '0) ? '0 :
                      (we_i && wAddr_i == rAddrA_i) ? wData_i : regs[rAddrA_i];
    assign rDataB_o = (rAddrB_i == '0) ? '0 :
                      (we_i && wAddr_i == rAddrB_i) ? wData_i : regs[rAddrB_i];

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module decodeStage (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  mips_pkg::word_t   instr_i,
    input  mips_pkg::word_t   pc_i,
    input  logic              valid_i,
    input  mips_pkg::word_t   rDataA_i,
    input  mips_pkg::word_t   rDataB_i,
    input  mips_pkg::word_t   fwdM_i,
    input  logic              brFwdA_i,
    input  logic              brFwdB_i,
    input  logic              bubble_i,
    output mips_pkg::regIdx_t rs_o,
    output mips_pkg::regIdx_t rt_o,
    output logic              isBranch_o,
    output logic              redirect_o,
    output mips_pkg::word_t   target_o,
    output mips_pkg::deReg_t  de_o
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;
    mips_pkg::regIdx_t rs;
    mips_pkg::regIdx_t rt;
    mips_pkg::regIdx_t rd;
    mips_pkg::regIdx_t dst;
    mips_pkg::word_t   imm;
    mips_pkg::word_t   pcPlus4;
    mips_pkg::word_t   opA;
    mips_pkg::word_t   opB;
    mips_pkg::ctrl_t   ctrl;
    mips_pkg::deReg_t  deNext;
    logic              useRs;
    logic              useRt;
    logic              isBeq;
    logic              isJump;

    assign opcode  = mips_pkg::opcode_e'(instr_i[31:26]);
    assign funct   = mips_pkg::funct_e'(instr_i[5:0]);
    assign rs      = instr_i[25:21];
    assign rt      = instr_i[20:16];
    assign rd      = instr_i[15:11];
    assign imm     = {{(`MIPS_XLEN-16){instr_i[15]}}, instr_i[15:0]};
    assign pcPlus4 = pc_i + mips_pkg::word_t'(4);

    always_comb begin
        ctrl   = `MIPS_STAGE_DEFAULT;
        dst    = rt;
        useRs  = 1'b0;
        useRt  = 1'b0;
        isBeq  = 1'b0;
        isJump = 1'b0;
        if (valid_i) begin
            case (opcode)
                mips_pkg::OP_SPECIAL: begin
                    dst           = rd;
                    useRs         = 1'b1;
                    useRt         = 1'b1;
                    ctrl.regWrite = 1'b1;
                    case (funct)
                        mips_pkg::FN_ADDU: ctrl.aluOp = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUBU: ctrl.aluOp = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND:  ctrl.aluOp = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:   ctrl.aluOp = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT:  ctrl.aluOp = mips_pkg::ALU_SLT;
                        // unknown funct, sll r0 included, runs as a nop
                        default: begin
                            ctrl.regWrite = 1'b0;
                            useRs         = 1'b0;
                            useRt         = 1'b0;
                        end
                    endcase
                end
                mips_pkg::OP_ADDIU: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.useImm   = 1'b1;
                    useRs         = 1'b1;
                end
                mips_pkg::OP_LW: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.useImm   = 1'b1;
                    ctrl.load     = 1'b1;
                    useRs         = 1'b1;
                end
                mips_pkg::OP_SW: begin
                    ctrl.useImm = 1'b1;
                    ctrl.store  = 1'b1;
                    useRs       = 1'b1;
                    useRt       = 1'b1;
                end
                mips_pkg::OP_BEQ: begin
                    isBeq = 1'b1;
                    useRs = 1'b1;
                    useRt = 1'b1;
                end
                mips_pkg::OP_J: isJump = 1'b1;
                default: ;
            endcase
            // writes to r0 are dropped here
            if (dst == '0) begin
                ctrl.regWrite = 1'b0;
            end
        end
    end

    // unread operand fields go out as r0 so they never stall
    assign rs_o = useRs ? rs : '0;
    assign rt_o = useRt ? rt : '0;

    assign opA        = brFwdA_i ? fwdM_i : rDataA_i;
    assign opB        = brFwdB_i ? fwdM_i : rDataB_i;
    assign isBranch_o = isBeq;
    assign redirect_o = isJump || (isBeq && opA == opB);
    assign target_o   = isJump ? {pcPlus4[`MIPS_XLEN-1:28], instr_i[25:0], 2'b00}
                               : pcPlus4 + (imm << 2);

    assign deNext = '{ctrl: ctrl, rs: rs_o, rt: rt_o, dst: dst, rsVal: rDataA_i,
                      rtVal: rDataB_i, imm: imm, pc: pc_i};

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            de_o <= `MIPS_STAGE_DEFAULT;
        end else if (bubble_i || !valid_i) begin
            de_o <= `MIPS_STAGE_DEFAULT;
        end else begin
            de_o <= deNext;
        end
    end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  mips_pkg::regIdx_t rsD_i,
    input  mips_pkg::regIdx_t rtD_i,
    input  logic              isBranchD_i,
    input  mips_pkg::deReg_t  de_i,
    input  mips_pkg::emReg_t  em_i,
    input  mips_pkg::regIdx_t wbReg_i,
    input  logic              wbWe_i,
    output mips_pkg::fwdSel_e fwdA_o,
    output mips_pkg::fwdSel_e fwdB_o,
    output logic              brFwdA_o,
    output logic              brFwdB_o,
    output logic              stallF_o,
    output logic              stallD_o,
    output logic              bubbleE_o
);

    logic loadUse;
    logic branchWait;
    logic emLoad;

    // true when src is produced by a writer of dst, r0 excluded
    function automatic logic dep(input mips_pkg::regIdx_t src,
                                 input mips_pkg::regIdx_t dst,
                                 input logic we);
        return we && (src != '0) && (src == dst);
    endfunction

    // M has priority over W
    assign fwdA_o = dep(de_i.rs, em_i.dst, em_i.ctrl.regWrite) ? mips_pkg::FWD_M :
                    dep(de_i.rs, wbReg_i, wbWe_i) ? mips_pkg::FWD_W : mips_pkg::FWD_RF;
    assign fwdB_o = dep(de_i.rt, em_i.dst, em_i.ctrl.regWrite) ? mips_pkg::FWD_M :
                    dep(de_i.rt, wbReg_i, wbWe_i) ? mips_pkg::FWD_W : mips_pkg::FWD_RF;

    assign brFwdA_o = dep(rsD_i, em_i.dst, em_i.ctrl.regWrite);
    assign brFwdB_o = dep(rtD_i, em_i.dst, em_i.ctrl.regWrite);

    assign emLoad  = em_i.ctrl.regWrite && em_i.ctrl.load;
    assign loadUse = de_i.ctrl.load && (dep(rsD_i, de_i.dst, de_i.ctrl.regWrite) ||
                                        dep(rtD_i, de_i.dst, de_i.ctrl.regWrite));

    // beq compares in D, so E results and M load data are too late
    assign branchWait = isBranchD_i && (dep(rsD_i, de_i.dst, de_i.ctrl.regWrite) ||
                                        dep(rtD_i, de_i.dst, de_i.ctrl.regWrite) ||
                                        dep(rsD_i, em_i.dst, emLoad) ||
                                        dep(rtD_i, em_i.dst, emLoad));

    assign stallD_o  = loadUse || branchWait;
    assign stallF_o  = stallD_o;
    assign bubbleE_o = stallD_o;

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module executeStage (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  mips_pkg::deReg_t  de_i,
    input  mips_pkg::fwdSel_e fwdA_i,
    input  mips_pkg::fwdSel_e fwdB_i,
    input  mips_pkg::word_t   fwdM_i,
    input  mips_pkg::word_t   fwdW_i,
    output mips_pkg::emReg_t  em_o
);

    mips_pkg::word_t opA;
    mips_pkg::word_t rtFwd;
    mips_pkg::word_t opB;
    mips_pkg::word_t aluRes;

    function automatic mips_pkg::word_t pick(input mips_pkg::fwdSel_e sel,
                                             input mips_pkg::word_t rfVal,
                                             input mips_pkg::word_t mVal,
                                             input mips_pkg::word_t wVal);
        case (sel)
            mips_pkg::FWD_M: return mVal;
            mips_pkg::FWD_W: return wVal;
            default:         return rfVal;
        endcase
    endfunction

    assign opA   = pick(fwdA_i, de_i.rsVal, fwdM_i, fwdW_i);
    assign rtFwd = pick(fwdB_i, de_i.rtVal, fwdM_i, fwdW_i);
    assign opB   = de_i.ctrl.useImm ? de_i.imm : rtFwd;

    always_comb begin
        case (de_i.ctrl.aluOp)
            mips_pkg::ALU_SUB: aluRes = opA - opB;
            mips_pkg::ALU_AND: aluRes = opA & opB;
            mips_pkg::ALU_OR:  aluRes = opA | opB;
            mips_pkg::ALU_SLT: aluRes = {{(`MIPS_XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default:           aluRes = opA + opB;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            em_o <= `MIPS_STAGE_DEFAULT;
        end else begin
            em_o.ctrl      <= de_i.ctrl;
            em_o.dst       <= de_i.dst;
            em_o.aluRes    <= aluRes;
            // store data is the forwarded rt
            em_o.storeData <= rtFwd;
            em_o.pc        <= de_i.pc;
        end
    end

endmodule

//--- logic/memArbiter.sv
`timescale 1ns/1ns

module memArbiter (
    input  logic              fetchReq_i,
    input  mips_pkg::word_t   fetchAddr_i,
    input  mips_pkg::emReg_t  em_i,
    output logic              memReq_o,
    output mips_pkg::memReq_t memCmd_o,
    output logic              fetchGrant_o
);

    logic dataReq;

    assign dataReq = em_i.ctrl.load || em_i.ctrl.store;

    // data access wins, fetch retries next cycle
    assign memReq_o     = dataReq || fetchReq_i;
    assign fetchGrant_o = fetchReq_i && !dataReq;

    always_comb begin
        if (dataReq) begin
            memCmd_o.we    = em_i.ctrl.store;
            memCmd_o.addr  = em_i.aluRes;
            memCmd_o.wdata = em_i.storeData;
        end else begin
            memCmd_o.we    = 1'b0;
            memCmd_o.addr  = fetchAddr_i;
            memCmd_o.wdata = '0;
        end
    end

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module mipsCore (
    input  logic              clk_i,
    input  logic              rstN_i,
    output logic              memReq_o,
    output mips_pkg::memReq_t memCmd_o,
    input  mips_pkg::word_t   memRdata_i,
    output logic              retireValid_o,
    output mips_pkg::retire_t retire_o
);

    logic              fetchReq;
    logic              fetchGrant;
    mips_pkg::word_t   pcF;
    mips_pkg::word_t   instrD;
    mips_pkg::word_t   pcD;
    logic              validD;
    logic              redirect;
    mips_pkg::word_t   target;
    mips_pkg::regIdx_t rsD;
    mips_pkg::regIdx_t rtD;
    logic              isBranchD;
    mips_pkg::word_t   rDataA;
    mips_pkg::word_t   rDataB;
    mips_pkg::deReg_t  de;
    mips_pkg::emReg_t  em;
    mips_pkg::fwdSel_e fwdA;
    mips_pkg::fwdSel_e fwdB;
    logic              brFwdA;
    logic              brFwdB;
    logic              stallF;
    logic              stallD;
    logic              bubbleE;
    logic              wbWe;
    mips_pkg::retire_t wbRec;
    mips_pkg::word_t   wbValue;

    fetchUnit i_fetchUnit (
        .clk_i(clk_i), .rstN_i(rstN_i), .stall_i(stallF || stallD), .grant_i(fetchGrant),
        .redirect_i(redirect), .target_i(target), .instr_i(memRdata_i),
        .fetchReq_o(fetchReq), .pc_o(pcF), .instrD_o(instrD), .pcD_o(pcD), .validD_o(validD)
    );

    regFile i_regFile (
        .clk_i(clk_i), .rstN_i(rstN_i), .we_i(wbWe), .wAddr_i(wbRec.rd),
        .wData_i(wbRec.value), .rAddrA_i(rsD), .rAddrB_i(rtD),
        .rDataA_o(rDataA), .rDataB_o(rDataB)
    );

    decodeStage i_decodeStage (
        .clk_i(clk_i), .rstN_i(rstN_i), .instr_i(instrD), .pc_i(pcD), .valid_i(validD),
        .rDataA_i(rDataA), .rDataB_i(rDataB), .fwdM_i(em.aluRes), .brFwdA_i(brFwdA),
        .brFwdB_i(brFwdB), .bubble_i(bubbleE), .rs_o(rsD), .rt_o(rtD),
        .isBranch_o(isBranchD), .redirect_o(redirect), .target_o(target), .de_o(de)
    );

    hazardUnit i_hazardUnit (
        .rsD_i(rsD), .rtD_i(rtD), .isBranchD_i(isBranchD), .de_i(de), .em_i(em),
        .wbReg_i(wbRec.rd), .wbWe_i(wbWe), .fwdA_o(fwdA), .fwdB_o(fwdB),
        .brFwdA_o(brFwdA), .brFwdB_o(brFwdB), .stallF_o(stallF), .stallD_o(stallD),
        .bubbleE_o(bubbleE)
    );

    executeStage i_executeStage (
        .clk_i(clk_i), .rstN_i(rstN_i), .de_i(de), .fwdA_i(fwdA), .fwdB_i(fwdB),
        .fwdM_i(em.aluRes), .fwdW_i(wbRec.value), .em_o(em)
    );

    memArbiter i_memArbiter (
        .fetchReq_i(fetchReq), .fetchAddr_i(pcF), .em_i(em), .memReq_o(memReq_o),
        .memCmd_o(memCmd_o), .fetchGrant_o(fetchGrant)
    );

    // load data arrives in M from the shared port
    assign wbValue = em.ctrl.load ? memRdata_i : em.aluRes;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            wbWe  <= 1'b0;
            wbRec <= `MIPS_STAGE_DEFAULT;
        end else begin
            wbWe  <= em.ctrl.regWrite;
            wbRec <= '{pc: em.pc, rd: em.dst, value: wbValue};
        end
    end

    assign retireValid_o = wbWe;
    assign retire_o      = wbRec;

endmodule

//--- sim/clockGen.sv
`timescale 1ns/1ns

module clockGen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rstN_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, away from the sampling point
    initial begin
        rstN_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstN_o = 1'b1;
    end

endmodule

//--- sim/mipsCore_checker.sv
`timescale 1ns/1ns

module mipsCore_checker (
    input logic              clk_i,
    input logic              rstN_i,
    input logic              memReq_o,
    input mips_pkg::memReq_t memCmd_o,
    input mips_pkg::word_t   memRdata_i,
    input logic              retireValid_o,
    input mips_pkg::retire_t retire_o
);

    // fetches and lw/sw are word accesses only
    alignedAddr: assert property (@(posedge clk_i) disable iff (!rstN_i)
        memReq_o |-> memCmd_o.addr[1:0] == 2'b00)
        else $error("memory access to unaligned address %h", memCmd_o.addr);

    noRetireR0: assert property (@(posedge clk_i) disable iff (!rstN_i)
        retireValid_o |-> retire_o.rd != '0)
        else $error("retire record names r0 at pc %h", retire_o.pc);

    writeHasReq: assert property (@(posedge clk_i) disable iff (!rstN_i)
        memCmd_o.we |-> memReq_o)
        else $error("write enable without a memory request");

    // every port known once out of reset
    portsKnown: assert property (@(posedge clk_i) disable iff (!rstN_i)
        !$isunknown({memReq_o, memCmd_o, memRdata_i, retireValid_o, retire_o}))
        else $error("unknown value on a core port");

endmodule

//--- sim/tb_mipsCore.sv
`timescale 1ns/1ns
`include "mips_cfg.svh"

module tb_mipsCore;

    localparam int CLK_PERIOD_NS  = 10;
    localparam int RESET_CYCLES   = 4;
    localparam int DRIVE_DELAY    = 1;
    localparam int PROG_LEN       = 200;
    localparam int MEM_WORDS      = 512;
    localparam int DATA_BASE      = 'h400;
    localparam int DATA_WORDS     = 32;
    localparam int USED_REGS      = 8;
    localparam int DRAIN_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 6 + 100;
    localparam mips_pkg::word_t SELF_PC = PROG_LEN * 4;

    logic              clk;
    logic              rstN;
    logic              memReq;
    mips_pkg::memReq_t memCmd;
    mips_pkg::word_t   memRdata;
    logic              retireValid;
    mips_pkg::retire_t retire;

    mips_pkg::word_t   mem [MEM_WORDS];
    mips_pkg::word_t   modelMem [MEM_WORDS];
    mips_pkg::retire_t expRetire [$];
    mips_pkg::memReq_t expStore [$];
    logic [31:0]       rngState;
    int                mismatches;
    int                otherErrors;
    int                retireCount;
    int                storeCount;
    int                expRetireTotal;
    int                expStoreTotal;
    logic              selfReached;
    logic              wrPend;
    mips_pkg::word_t   wrAddr;
    mips_pkg::word_t   wrData;

    clockGen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clockGen (
        .clk_o(clk), .rstN_o(rstN)
    );

    mipsCore i_mipsCore (
        .clk_i(clk), .rstN_i(rstN), .memReq_o(memReq), .memCmd_o(memCmd),
        .memRdata_i(memRdata), .retireValid_o(retireValid), .retire_o(retire)
    );

    bind mipsCore mipsCore_checker i_mipsCore_checker (
        .clk_i(clk_i), .rstN_i(rstN_i), .memReq_o(memReq_o), .memCmd_o(memCmd_o),
        .memRdata_i(memRdata_i), .retireValid_o(retireValid_o), .retire_o(retire_o)
    );

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic int randBelow(input int n);
        return int'((nextRand() >> 8) % n);
    endfunction

    // 512 words use address bits 10:2
    function automatic int wordIdx(input mips_pkg::word_t addr);
        return int'(addr[10:2]);
    endfunction

    function automatic mips_pkg::word_t fillWord(input mips_pkg::word_t addr);
        return addr * 32'h9e37_79b9 ^ 32'h5bd1_e995;
    endfunction

    function automatic mips_pkg::word_t rType(input logic [5:0] fn, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic mips_pkg::word_t iType(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] randFunct();
        case (randBelow(5))
            0:       return 6'h21;
            1:       return 6'h23;
            2:       return 6'h24;
            3:       return 6'h25;
            default: return 6'h2a;
        endcase
    endfunction

    function automatic logic [15:0] dataOffset();
        return 16'(DATA_BASE + 4 * randBelow(DATA_WORDS));
    endfunction

    task automatic buildProgram();
        int              kind;
        int              span;
        logic            prevCtrl;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
        mips_pkg::word_t w;
        prevCtrl = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fillWord(mips_pkg::word_t'(i * 4));
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rs   = 5'(randBelow(USED_REGS));
            rt   = 5'(randBelow(USED_REGS));
            rd   = 5'(randBelow(USED_REGS));
            kind = randBelow(16);
            // no control flow in a delay slot or just before the self-jump
            if (kind >= 13 && (prevCtrl || i == PROG_LEN - 1)) begin
                kind = randBelow(13);
            end
            span = (PROG_LEN - i - 1 < 6) ? PROG_LEN - i - 1 : 6;
            case (kind)
                0, 1, 2, 3, 4, 5: w = rType(randFunct(), rs, rt, rd);
                6, 7, 8:          w = iType(6'h09, rs, rt, 16'(randBelow(65536)));
                9, 10:            w = iType(6'h23, 5'd0, rt, dataOffset());
                11, 12:           w = iType(6'h2b, 5'd0, rt, dataOffset());
                13, 14:           w = iType(6'h04, rs, rt, 16'(1 + randBelow(span)));
                default:          w = {6'h02, 26'(i + 2 + randBelow(span))};
            endcase
            mem[i]   = w;
            prevCtrl = (kind >= 13);
        end
        // self-jump with a nop in its delay slot
        mem[PROG_LEN]     = {6'h02, 26'(PROG_LEN)};
        mem[PROG_LEN + 1] = '0;
    endtask

    // architectural model with one delay slot per branch or jump
    task automatic runModel();
        mips_pkg::word_t regs [`MIPS_NREGS];
        mips_pkg::word_t pc;
        mips_pkg::word_t npc;
        mips_pkg::word_t nnpc;
        mips_pkg::word_t w;
        mips_pkg::word_t imm;
        mips_pkg::word_t res;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      dst;
        logic            wr;
        int              steps;
        for (int r = 0; r < `MIPS_NREGS; r++) begin
            regs[r] = '0;
        end
        pc    = `MIPS_RESET_PC;
        npc   = pc + 4;
        steps = 0;
        while (pc != SELF_PC && steps < 2 * PROG_LEN) begin
            w    = modelMem[wordIdx(pc)];
            rs   = w[25:21];
            rt   = w[20:16];
            imm  = {{16{w[15]}}, w[15:0]};
            nnpc = npc + 4;
            wr   = 1'b0;
            dst  = rt;
            res  = '0;
            case (w[31:26])
                6'h00: begin
                    dst = w[15:11];
                    wr  = 1'b1;
                    case (w[5:0])
                        6'h21:   res = regs[rs] + regs[rt];
                        6'h23:   res = regs[rs] - regs[rt];
                        6'h24:   res = regs[rs] & regs[rt];
                        6'h25:   res = regs[rs] | regs[rt];
                        6'h2a:   res = ($signed(regs[rs]) < $signed(regs[rt])) ? 1 : 0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: begin
                    res = regs[rs] + imm;
                    wr  = 1'b1;
                end
                6'h23: begin
                    res = modelMem[wordIdx(regs[rs] + imm)];
                    wr  = 1'b1;
                end
                6'h2b: begin
                    modelMem[wordIdx(regs[rs] + imm)] = regs[rt];
                    expStore.push_back('{we: 1'b1, addr: regs[rs] + imm, wdata: regs[rt]});
                end
                6'h04: begin
                    if (regs[rs] == regs[rt]) begin
                        nnpc = pc + 4 + (imm << 2);
                    end
                end
                6'h02: nnpc = {npc[31:28], w[25:0], 2'b00};
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                expRetire.push_back('{pc: pc, rd: dst, value: res});
            end
            pc    = npc;
            npc   = nnpc;
            steps = steps + 1;
        end
        if (pc != SELF_PC) begin
            otherErrors++;
            $display("ERROR: reference model never reached the self-jump at %h", SELF_PC);
        end
    endtask

    task automatic checkRetire(input string testName, input mips_pkg::retire_t expected,
                               input mips_pkg::retire_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected pc %h r%0d = %h, actual pc %h r%0d = %h",
                     testName, expected.pc, expected.rd, expected.value,
                     actual.pc, actual.rd, actual.value);
        end
    endtask

    task automatic checkStore(input string testName, input mips_pkg::memReq_t expected,
                              input mips_pkg::memReq_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected we %b [%h] = %h, actual we %b [%h] = %h",
                     testName, expected.we, expected.addr, expected.wdata,
                     actual.we, actual.addr, actual.wdata);
        end
    endtask

    // store lands on the edge and read data follows the command
    always @(posedge clk) begin
        if (wrPend) begin
            mem[wordIdx(wrAddr)] = wrData;
            wrPend = 1'b0;
        end
        #(DRIVE_DELAY);
        memRdata = mem[wordIdx(memCmd.addr)];
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            if (retireValid) begin
                if (expRetire.size() == 0) begin
                    otherErrors++;
                    $display("ERROR: extra retire at pc %h beyond the model's %0d records",
                             retire.pc, expRetireTotal);
                end else begin
                    checkRetire($sformatf("retire %0d", retireCount), expRetire.pop_front(),
                                retire);
                end
                retireCount++;
            end
            if (memReq && memCmd.we) begin
                if (expStore.size() == 0) begin
                    otherErrors++;
                    $display("ERROR: extra store to %h beyond the model's %0d stores",
                             memCmd.addr, expStoreTotal);
                end else begin
                    checkStore($sformatf("store %0d", storeCount), expStore.pop_front(), memCmd);
                end
                storeCount++;
                wrPend = 1'b1;
                wrAddr = memCmd.addr;
                wrData = memCmd.wdata;
            end
            if (memReq && !memCmd.we && memCmd.addr == SELF_PC) begin
                selfReached = 1'b1;
            end
        end
    end

    initial begin
        memRdata    = '0;
        mismatches  = 0;
        otherErrors = 0;
        retireCount = 0;
        storeCount  = 0;
        selfReached = 1'b0;
        wrPend      = 1'b0;
        wrAddr      = '0;
        wrData      = '0;
        rngState    = 32'hcc26_76c1;
        buildProgram();
        modelMem = mem;
        runModel();
        expRetireTotal = expRetire.size();
        expStoreTotal  = expStore.size();
        @(posedge rstN);
        while (!(selfReached && retireCount >= expRetireTotal
                 && storeCount >= expStoreTotal)) begin
            @(posedge clk);
        end
        // a few more cycles to catch anything retiring past the end
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("%0d mismatches, %0d other errors, %0d of %0d retires, %0d of %0d stores",
                 mismatches, otherErrors, retireCount, expRetireTotal,
                 storeCount, expStoreTotal);
        if (mismatches == 0 && otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((TIMEOUT_CYCLES + RESET_CYCLES) * CLK_PERIOD_NS);
        otherErrors++;
        $display("ERROR: timeout, program did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("%0d mismatches, %0d other errors, %0d of %0d retires, %0d of %0d stores",
                 mismatches, otherErrors, retireCount, expRetireTotal,
                 storeCount, expStoreTotal);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
logic/mips_pkg.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/decodeStage.sv
logic/hazardUnit.sv
logic/executeStage.sv
logic/memArbiter.sv
logic/mipsCore.sv
sim/clockGen.sv
sim/mipsCore_checker.sv
sim/tb_mipsCore.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - files:
      - logic/mips_pkg.sv
      - logic/fetchUnit.sv
      - logic/regFile.sv
      - logic/decodeStage.sv
      - logic/hazardUnit.sv
      - logic/executeStage.sv
      - logic/memArbiter.sv
      - logic/mipsCore.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/mipsCore_checker.sv
      - sim/tb_mipsCore.sv
